// ==== project.f ====
src/issue_pkg.sv
src/reg_file.sv
src/issue_stage.sv
src/exec_lane.sv
src/writeback.sv
src/issue_top.sv
test/tb_clock.sv
test/issue_tb.sv

// ==== Bender.yml ====
package:
  name: issue_slice

sources:
  - files:
      - src/issue_pkg.sv
      - src/reg_file.sv
      - src/issue_stage.sv
      - src/exec_lane.sv
      - src/writeback.sv
      - src/issue_top.sv
  - target: test
    files:
      - test/tb_clock.sv
      - test/issue_tb.sv

// ==== test/issue_tb.sv ====
/*
 * directed tests for the issue and execute slice. the testbench acts as
 * decode, runs each program through a reference model and checks every
 * commit in order.
 */
`timescale 1ns/100ps

module issue_tb import issue_pkg::*; ();

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] result;
        logic [6:0]  exception;
        logic        dep;
    } expect_t;

    logic clk, arst_n, flush, has_interrupt, stall;
    instr_t in0, in1;
    logic [1:0] num_read;
    commit_t [num_lanes-1:0] commit;
    logic [num_lanes-1:0] commit_valid;

    instr_t      prog[$];
    bit          irq_flag[$];
    expect_t     exp_q[$];
    logic [31:0] model_regs [32];
    logic [31:0] lcg_state;
    logic [31:0] next_pc;
    logic [1:0]  last_nr;
    int          ptr, errors, tests_run, pairs_seen;
    bit          expect_quiet;
    string       test_name;

    tb_clock tb_clock_inst (.clk(clk), .arst_n(arst_n));

    issue_top issue_top_inst (
        .clk(clk), .arst_n(arst_n), .flush(flush), .has_interrupt(has_interrupt),
        .stall(stall), .in0(in0), .in1(in1), .num_read(num_read),
        .commit(commit), .commit_valid(commit_valid)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = lcg_next();
        return 5'(r % 31) + 5'd1;
    endfunction

    function automatic op_e rand_op();
        logic [31:0] r;
        r = lcg_next();
        return op_e'(4'(r % 9) + 4'd1);
    endfunction

    // expected ALU behavior per operation
    function automatic logic [31:0] alu_model(op_e op, logic [31:0] a, logic [31:0] b,
                                             logic [31:0] imm);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_addi: return a + imm;
            op_lui:  return imm;
            default: return 32'd0;
        endcase
    endfunction

    task automatic add_instr(op_e op, logic [4:0] rd, logic [4:0] rj, logic [4:0] rk,
                             logic [31:0] imm, logic [6:0] exc, bit take_irq);
        instr_t i;
        i = '0;
        i.op = op;
        i.rd = rd;
        i.rj = rj;
        i.rk = rk;
        i.imm = imm;
        i.exception = exc;
        i.pc = next_pc;
        i.pc_next = next_pc + 32'd4;
        next_pc = next_pc + 32'd4;
        prog.push_back(i);
        irq_flag.push_back(take_irq);
    endtask

    // destinations in 16..31 and sources in 0..15 so no pair depends
    task automatic add_random_indep(int n);
        for (int k = 0; k < n; k++) begin
            add_instr(rand_op(), rand_reg() | 5'h10, rand_reg() & 5'h0f,
                      rand_reg() & 5'h0f, lcg_next(), exc_none, 1'b0);
        end
    endtask

    task automatic present();
        instr_t empty;
        empty = '0;
        in0 <= (ptr < prog.size()) ? prog[ptr] : empty;
        in1 <= (ptr + 1 < prog.size()) ? prog[ptr + 1] : empty;
        has_interrupt <= (ptr < prog.size()) ? irq_flag[ptr] : 1'b0;
    endtask

    task automatic check_field(string field, logic [31:0] expected, logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch in %s: %s expected %h actual %h",
                     test_name, field, expected, actual);
        end
    endtask

    // one clock edge that samples outputs, checks commits and feeds decode
    task automatic step();
        logic [1:0] cv;
        commit_t [num_lanes-1:0] cm;
        expect_t e;
        @(posedge clk);
        last_nr = num_read;
        cv = commit_valid;
        cm = commit;
        if (expect_quiet && cv != 2'b00) begin
            errors++;
            $display("%s: commit reported in a cycle that should have none", test_name);
        end
        if (cv == 2'b11) begin
            pairs_seen++;
        end
        for (int s = 0; s < num_lanes; s++) begin
            if (cv[s] && exp_q.size() == 0) begin
                errors++;
                $display("%s: unexpected commit in slot %0d, pc %h", test_name, s, cm[s].pc);
            end else if (cv[s]) begin
                e = exp_q.pop_front();
                if (s == 1 && cv[0] && e.dep) begin
                    errors++;
                    $display("%s: dependent pair committed together, pc %h", test_name, e.pc);
                end
                check_field("pc", e.pc, cm[s].pc);
                check_field("rd", 32'(e.rd), 32'(cm[s].rd));
                check_field("wen", 32'(e.wen), 32'(cm[s].wen));
                check_field("exception", 32'(e.exception), 32'(cm[s].exception));
                if (e.exception == exc_none) begin
                    check_field("result", e.result, cm[s].result);
                end
            end
        end
        ptr += (last_nr == 2'b11) ? 2 : (last_nr == 2'b01) ? 1 : 0;
        if (ptr > prog.size()) begin
            ptr = prog.size();
        end
        present();
    endtask

    // reference model runs the program in order and skips empty slots
    task automatic load_prog(string name);
        expect_t e;
        instr_t i;
        logic [4:0] prev_rd;
        bit have_prev;
        test_name = name;
        tests_run++;
        pairs_seen = 0;
        have_prev = 1'b0;
        prev_rd = 5'd0;
        for (int k = 0; k < prog.size(); k++) begin
            i = prog[k];
            if (i.op != op_nop || i.exception != exc_none || irq_flag[k]) begin
                e.exception = irq_flag[k] ? exc_int : i.exception;
                e.pc = i.pc;
                e.rd = i.rd;
                e.wen = e.exception == exc_none && i.rd != 5'd0;
                e.result = alu_model(i.op, model_regs[i.rj], model_regs[i.rk], i.imm);
                e.dep = have_prev && prev_rd != 5'd0 && (i.rj == prev_rd || i.rk == prev_rd);
                if (e.wen) begin
                    model_regs[i.rd] = e.result;
                end
                prev_rd = i.rd;
                have_prev = 1'b1;
                exp_q.push_back(e);
            end
        end
        ptr = 0;
        present();
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while ((exp_q.size() != 0 || ptr < prog.size()) && cycles < 400) begin
            step();
            cycles++;
        end
        if (exp_q.size() != 0 || ptr < prog.size()) begin
            errors++;
            $display("%s: timed out with %0d commits outstanding", test_name, exp_q.size());
            exp_q.delete();
        end
        // a few more edges to catch stray commits
        repeat (3) step();
        prog.delete();
        irq_flag.delete();
        ptr = 0;
    endtask

    task automatic independent_pairs();
        for (int r = 1; r < 32; r++) begin
            add_instr(op_lui, 5'(r), 5'd0, 5'd0, lcg_next(), exc_none, 1'b0);
        end
        add_random_indep(24);
        load_prog("independent");
        drain();
        if (pairs_seen == 0) begin
            errors++;
            $display("independent: no cycle committed two instructions");
        end
    endtask

    task automatic dependent_pairs();
        logic [4:0] rd;
        for (int k = 0; k < 8; k++) begin
            rd = rand_reg();
            add_instr(rand_op(), rd, rand_reg(), rand_reg(), lcg_next(), exc_none, 1'b0);
            add_instr(op_add, rand_reg(), rd, rand_reg(), 32'd0, exc_none, 1'b0);
        end
        load_prog("dependent");
        drain();
    endtask

    // each instruction reads the previous result through the bypass
    task automatic bypass_chain();
        logic [4:0] prev;
        logic [4:0] rd;
        prev = rand_reg();
        for (int k = 0; k < 12; k++) begin
            rd = rand_reg();
            add_instr((k % 2) ? op_add : op_addi, rd, prev, prev, lcg_next(), exc_none, 1'b0);
            prev = rd;
        end
        load_prog("chain");
        drain();
    endtask

    task automatic nop_slots();
        add_instr(op_nop, 5'd0, 5'd0, 5'd0, 32'd0, exc_none, 1'b0);
        add_instr(op_nop, 5'd0, 5'd0, 5'd0, 32'd0, exc_none, 1'b0);
        for (int k = 0; k < 18; k++) begin
            if (k % 3 == 1 || k == 9) begin
                add_instr(op_nop, 5'd0, 5'd0, 5'd0, 32'd0, exc_none, 1'b0);
            end else begin
                add_instr(rand_op(), rand_reg(), rand_reg(), rand_reg(), lcg_next(),
                          exc_none, 1'b0);
            end
        end
        load_prog("nops");
        drain();
    endtask

    // interrupt lands on the first entry, which is always in0 when taken
    task automatic exception_codes();
        add_instr(op_add, 5'd6, 5'd5, 5'd5, 32'd0, exc_none, 1'b1);
        add_instr(op_add, 5'd7, 5'd6, 5'd0, 32'd0, exc_none, 1'b0);
        add_instr(op_lui, 5'd8, 5'd0, 5'd0, lcg_next(), 7'h05, 1'b0);
        add_instr(op_add, 5'd9, 5'd8, 5'd6, 32'd0, exc_none, 1'b0);
        load_prog("exceptions");
        drain();
    endtask

    task automatic stall_and_flush();
        add_random_indep(20);
        load_prog("stall");
        repeat (4) step();
        stall <= 1'b1;
        step();
        expect_quiet = 1'b1;
        repeat (6) step();
        expect_quiet = 1'b0;
        stall <= 1'b0;
        drain();
        // fill the buffer with lanes blocked, then flush it away
        test_name = "flush";
        tests_run++;
        stall <= 1'b1;
        add_random_indep(2);
        ptr = 0;
        present();
        repeat (2) step();
        if (last_nr !== 2'b00) begin
            errors++;
            $display("mismatch in flush: num_read expected 00 actual %b", last_nr);
        end
        flush <= 1'b1;
        step();
        flush <= 1'b0;
        prog.delete();
        irq_flag.delete();
        ptr = 0;
        step();
        if (last_nr !== 2'b11) begin
            errors++;
            $display("mismatch in flush: num_read expected 11 actual %b", last_nr);
        end
        stall <= 1'b0;
        repeat (4) step();
    endtask

    initial begin
        flush = 1'b0;
        has_interrupt = 1'b0;
        stall = 1'b0;
        in0 = '0;
        in1 = '0;
        lcg_state = 32'h786af533;
        next_pc = 32'h0000_1000;
        errors = 0;
        tests_run = 0;
        ptr = 0;
        expect_quiet = 1'b0;
        test_name = "reset";
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'd0;
        end
        for (int i = 0; i < 20 && arst_n !== 1'b1; i++) begin
            @(posedge clk);
        end
        if (arst_n !== 1'b1) begin
            errors++;
            $display("reset was never released");
        end
        expect_quiet = 1'b1;
        step();
        expect_quiet = 1'b0;
        if (last_nr !== 2'b11) begin
            errors++;
            $display("mismatch in reset: num_read expected 11 actual %b", last_nr);
        end
        independent_pairs();
        dependent_pairs();
        bypass_chain();
        nop_slots();
        exception_codes();
        stall_and_flush();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
/*
 * testbench clock and reset source, 10 ns period,
 * reset held low for the first four rising edges
 */
`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

// ==== src/issue_top.sv ====
/*
 * issue and execute slice of the dual-issue core. decode drives
 * in0/in1 and advances by num_read; committed instructions come
 * out two cycles after issue.
 */
`timescale 1ns/100ps

module issue_top import issue_pkg::*; (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       flush,
    input  logic                       has_interrupt,
    input  logic                       stall,
    input  instr_t                     in0,
    input  instr_t                     in1,
    output logic [1:0]                 num_read,
    output commit_t [num_lanes-1:0]    commit,
    output logic [num_lanes-1:0]       commit_valid
);

    logic [num_lanes-1:0]              lane_ready;
    logic [num_lanes-1:0]              lane_en;
    instr_t [num_lanes-1:0]            lane_instr;
    lane_res_t [num_lanes-1:0]         lane_res;
    logic                              hold;
    logic [2*num_lanes-1:0][4:0]       rf_raddr;
    logic [2*num_lanes-1:0][31:0]      rf_rdata;
    logic [num_lanes-1:0]              rf_wen;
    logic [num_lanes-1:0][4:0]         rf_waddr;
    logic [num_lanes-1:0][31:0]        rf_wdata;

    issue_stage issue_stage_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .flush         (flush),
        .has_interrupt (has_interrupt),
        .in0           (in0),
        .in1           (in1),
        .num_read      (num_read),
        .lane_ready    (lane_ready),
        .lane_en       (lane_en),
        .lane_instr    (lane_instr)
    );

    // each lane owns two consecutive read ports
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign rf_raddr[2*i]   = lane_instr[i].rj;
        assign rf_raddr[2*i+1] = lane_instr[i].rk;

        exec_lane exec_lane_inst (
            .clk     (clk),
            .arst_n  (arst_n),
            .flush   (flush),
            .hold    (hold),
            .en      (lane_en[i]),
            .instr   (lane_instr[i]),
            .ready   (lane_ready[i]),
            .rj_data (rf_rdata[2*i]),
            .rk_data (rf_rdata[2*i+1]),
            .res     (lane_res[i])
        );
    end

    reg_file reg_file_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (rf_raddr),
        .rdata  (rf_rdata),
        .wen    (rf_wen),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    writeback writeback_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .lane_res     (lane_res),
        .hold         (hold),
        .wen          (rf_wen),
        .waddr        (rf_waddr),
        .wdata        (rf_wdata),
        .commit       (commit),
        .commit_valid (commit_valid)
    );

endmodule

// ==== src/writeback.sv ====
/*
 * drains both lanes into the register file and registers the
 * commit reports, slot 0 holding the older instruction.
 * stall freezes the lanes and suppresses writes and commits.
 */
`timescale 1ns/100ps

module writeback import issue_pkg::*; (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           stall,
    input  lane_res_t [num_lanes-1:0]      lane_res,
    output logic                           hold,
    output logic [num_lanes-1:0]           wen,
    output logic [num_lanes-1:0][4:0]      waddr,
    output logic [num_lanes-1:0][31:0]     wdata,
    output commit_t [num_lanes-1:0]        commit,
    output logic [num_lanes-1:0]           commit_valid
);

    logic [num_lanes-1:0] drain;

    assign hold = stall;

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            drain[i] = lane_res[i].valid && !stall;
            // no write for exceptions or r0
            wen[i]   = drain[i] && lane_res[i].instr.exception == exc_none &&
                       lane_res[i].instr.rd != 5'd0;
            waddr[i] = lane_res[i].instr.rd;
            wdata[i] = lane_res[i].result;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= '0;
        end else begin
            commit_valid <= drain;
        end
    end

    // commit report per slot
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_lanes; i++) begin
            commit[i] <= '{pc:        lane_res[i].instr.pc,
                           rd:        lane_res[i].instr.rd,
                           wen:       wen[i],
                           result:    lane_res[i].result,
                           exception: lane_res[i].instr.exception};
        end
    end

endmodule

// ==== src/exec_lane.sv ====
/*
 * one integer execute lane. takes an issued instruction and its
 * operands at the issue edge and presents the ALU result to
 * writeback until it drains.
 */
`timescale 1ns/100ps

module exec_lane import issue_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        hold,
    input  logic        en,
    input  instr_t      instr,
    output logic        ready,
    input  logic [31:0] rj_data,
    input  logic [31:0] rk_data,
    output lane_res_t   res
);

    logic        valid_q;
    instr_t      instr_q;
    logic [31:0] rj_q;
    logic [31:0] rk_q;
    logic [31:0] alu_result;

    assign ready = !hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (flush) begin
            valid_q <= 1'b0;
        end else if (!hold) begin
            // drains unless a new one arrives
            valid_q <= en;
        end
    end

    always_ff @(posedge clk) begin
        if (en && !hold) begin
            instr_q <= instr;
            rj_q    <= rj_data;
            rk_q    <= rk_data;
        end
    end

    always_comb begin
        case (instr_q.op)
            op_add:  alu_result = rj_q + rk_q;
            op_sub:  alu_result = rj_q - rk_q;
            op_and:  alu_result = rj_q & rk_q;
            op_or:   alu_result = rj_q | rk_q;
            op_xor:  alu_result = rj_q ^ rk_q;
            op_sll:  alu_result = rj_q << rk_q[4:0];
            op_srl:  alu_result = rj_q >> rk_q[4:0];
            op_addi: alu_result = rj_q + instr_q.imm;
            op_lui:  alu_result = instr_q.imm;
            default: alu_result = '0;
        endcase
        // excepting instructions carry no result
        if (instr_q.exception != exc_none) begin
            alu_result = '0;
        end
    end

    assign res = '{valid: valid_q, instr: instr_q, result: alu_result};

endmodule

// ==== src/issue_stage.sv ====
/*
 * in-order dual-issue stage with a two-entry buffer.
 * reports the accepted count back to decode, tags interrupts and
 * sends the older entry to lane 0, the younger to lane 1.
 */
`timescale 1ns/100ps

module issue_stage import issue_pkg::*; (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        flush,
    input  logic                        has_interrupt,
    input  instr_t                      in0,
    input  instr_t                      in1,
    output logic [1:0]                  num_read,
    input  logic [num_lanes-1:0]        lane_ready,
    output logic [num_lanes-1:0]        lane_en,
    output instr_t [num_lanes-1:0]      lane_instr
);

    instr_t [1:0] buf_q;
    instr_t [1:0] buf_d;
    logic [1:0]   count_q;
    logic [1:0]   count_d;
    instr_t       in0_tag;
    instr_t [1:0] new_instr;
    logic [1:0]   new_cnt;
    logic [1:0]   left;
    logic         dep;

    // empty slot has no operation and no exception
    function automatic logic is_nop(instr_t i);
        return i.op == op_nop && i.exception == exc_none;
    endfunction

    // interrupt is taken on the older incoming slot
    always_comb begin
        in0_tag = in0;
        if (has_interrupt) begin
            in0_tag.exception = exc_int;
        end
    end

    // younger entry reads the older one's destination
    assign dep = buf_q[0].rd != 5'd0 &&
                 (buf_q[1].rj == buf_q[0].rd || buf_q[1].rk == buf_q[0].rd);

    assign lane_en[0] = lane_ready[0] && count_q != 2'd0 && !is_nop(buf_q[0]);
    assign lane_en[1] = lane_en[0] && lane_ready[1] && count_q == 2'd2 &&
                        !is_nop(buf_q[1]) && !dep;

    assign lane_instr = buf_q;

    // occupancy left once this cycle's issues are gone
    assign left = count_q - {1'b0, lane_en[0]} - {1'b0, lane_en[1]};

    always_comb begin
        case (left)
            2'd2:    num_read = 2'b00;
            2'd1:    num_read = 2'b01;
            default: num_read = 2'b11;
        endcase
    end

    // accepted instructions, compacted so nops take no entry
    always_comb begin
        new_instr[0] = in0_tag;
        new_instr[1] = in1;
        new_cnt      = 2'd0;
        case (num_read)
            2'b11: begin
                if (is_nop(in0_tag)) begin
                    // younger slot moves up
                    new_instr[0] = in1;
                    new_cnt      = is_nop(in1) ? 2'd0 : 2'd1;
                end else begin
                    new_cnt = is_nop(in1) ? 2'd1 : 2'd2;
                end
            end
            2'b01: begin
                new_cnt = is_nop(in0_tag) ? 2'd0 : 2'd1;
            end
            default: begin
                new_cnt = 2'd0;
            end
        endcase
    end

    always_comb begin
        buf_d = buf_q;
        // on a single issue the survivor moves to the head
        if (lane_en[0] && !lane_en[1]) begin
            buf_d[0] = buf_q[1];
        end
        case (left)
            2'd0: begin
                buf_d[0] = new_instr[0];
                buf_d[1] = new_instr[1];
            end
            2'd1: begin
                buf_d[1] = new_instr[0];
            end
            default: begin
                buf_d[1] = buf_q[1];
            end
        endcase
        count_d = left + new_cnt;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_q <= 2'd0;
        end else if (flush) begin
            count_q <= 2'd0;
        end else begin
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk) begin
        buf_q <= buf_d;
    end

endmodule

// ==== src/reg_file.sv ====
/*
 * integer register file, 31 registers plus hardwired zero.
 * four read ports for two lanes, two write ports from writeback;
 * reads see same-cycle writes, the younger write port wins.
 */
`timescale 1ns/100ps

module reg_file import issue_pkg::*; (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [2*num_lanes-1:0][4:0]        raddr,
    output logic [2*num_lanes-1:0][31:0]       rdata,
    input  logic [num_lanes-1:0]               wen,
    input  logic [num_lanes-1:0][4:0]          waddr,
    input  logic [num_lanes-1:0][31:0]         wdata
);

    logic [31:0] regs_q [num_regs-1:1];

    // port order gives lane 1 the last word on a shared address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 1; r < num_regs; r++) begin
                regs_q[r] <= '0;
            end
        end else begin
            for (int w = 0; w < num_lanes; w++) begin
                if (wen[w] && waddr[w] != 5'd0) begin
                    regs_q[waddr[w]] <= wdata[w];
                end
            end
        end
    end

    // write-through bypass where the later port overrides the earlier
    always_comb begin
        for (int p = 0; p < 2 * num_lanes; p++) begin
            if (raddr[p] == 5'd0) begin
                rdata[p] = '0;
            end else begin
                rdata[p] = regs_q[raddr[p]];
                for (int w = 0; w < num_lanes; w++) begin
                    if (wen[w] && waddr[w] == raddr[p]) begin
                        rdata[p] = wdata[w];
                    end
                end
            end
        end
    end

endmodule

// ==== src/issue_pkg.sv ====
/*
 * shared constants and types for the dual-issue integer slice.
 * modules pull these in with a wildcard import in their header.
 */
package issue_pkg;

    // the pairwise issue rules only work for two lanes
    localparam int num_lanes = 2;

    // register fields are 5 bits wide
    localparam int num_regs = 32;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_sll  = 4'd6,
        op_srl  = 4'd7,
        op_addi = 4'd8,
        op_lui  = 4'd9
    } op_e;

    // exception codes where zero means none
    localparam logic [6:0] exc_none = 7'h00;
    localparam logic [6:0] exc_int  = 7'h40;

    // one decoded instruction as offered by decode
    typedef struct packed {
        op_e         op;
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        logic [31:0] imm;
        logic [6:0]  exception;
        logic [31:0] pc;
        logic [31:0] pc_next;
    } instr_t;

    // one retired instruction, reported in program order
    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic        wen;
        logic [31:0] result;
        logic [6:0]  exception;
    } commit_t;

    // what an execute lane hands to writeback
    typedef struct packed {
        logic        valid;
        instr_t      instr;
        logic [31:0] result;
    } lane_res_t;

endpackage
